//--- verilog/simmem_pkg.sv
/*
 * Shared sizes of the write-response bank.
 * The widths must stay consistent with the counts: BankAddrWidth covers
 * TotCapa slots, IdWidth covers NumIds identifiers, and LenWidth must
 * hold the value TotCapa itself.
 */

package simmem_pkg;

  ////////////////////////////////////////////////////////////
  // AXI identifiers
  ////////////////////////////////////////////////////////////

  // Number of distinct write identifiers
  localparam int unsigned NumIds = 4;
  // Binary identifier width
  localparam int unsigned IdWidth = 2;

  ////////////////////////////////////////////////////////////
  // Response payload
  ////////////////////////////////////////////////////////////

  // Response content stored in the bank, identifier excluded
  localparam int unsigned ContentWidth = 6;

  ////////////////////////////////////////////////////////////
  // Slot pool
  ////////////////////////////////////////////////////////////

  // Total slots shared by all identifiers
  localparam int unsigned TotCapa = 8;
  // Binary slot address width
  localparam int unsigned BankAddrWidth = 3;

  // Per-identifier counters, wide enough to count 0 to TotCapa
  localparam int unsigned LenWidth = 4;

endpackage

//--- verilog/simmem_msg_ram.sv
/*
 * Response content store, one word per bank slot.
 * One write port and one read port, both on clk_i.
 * Read data is registered and appears one cycle after the address.
 * No reset: a word holds garbage until its slot has been filled.
 */

`timescale 1ns/100ps

module simmem_msg_ram
  import simmem_pkg::*;
(
  input  logic                     clk_i,

  // Write port
  input  logic                     i_wr_en,
  input  logic [BankAddrWidth-1:0] i_wr_addr,
  input  logic [ContentWidth-1:0]  i_wr_data,

  // Read port
  input  logic [BankAddrWidth-1:0] i_rd_addr,
  output logic [ContentWidth-1:0]  o_rd_data
);

  logic [ContentWidth-1:0] mem_q [TotCapa];

  always_ff @(posedge clk_i) begin
    if (i_wr_en) begin
      mem_q[i_wr_addr] <= i_wr_data;
    end
  end

  // A read of the slot written in the same cycle returns the old word
  always_ff @(posedge clk_i) begin
    o_rd_data <= mem_q[i_rd_addr];
  end

endmodule

//--- verilog/simmem_slot_alloc.sv
/*
 * Slot occupancy tracking for the bank.
 * A slot is busy from the cycle after its reservation until the cycle
 * after its release. The free address is the lowest free slot and is
 * only meaningful while o_any_free is high.
 */

`timescale 1ns/100ps

module simmem_slot_alloc
  import simmem_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Completed reservation, takes the current free address
  input  logic                     i_res_done,
  // Slots freed by an output handshake
  input  logic [TotCapa-1:0]       i_rel_onehot,

  output logic [BankAddrWidth-1:0] o_free_addr,
  output logic                     o_any_free
);

  logic [TotCapa-1:0]       valid_d;
  logic [TotCapa-1:0]       valid_q;
  logic [TotCapa-1:0]       res_mask;
  logic [BankAddrWidth-1:0] free_addr;

  ////////////////////////////////////////////////////////////
  // Lowest free slot
  ////////////////////////////////////////////////////////////

  // Scan downwards so the lowest free index is the last one kept
  always_comb begin
    free_addr = '0;
    for (int i = TotCapa - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_addr = BankAddrWidth'(i);
      end
    end
  end

  assign o_free_addr = free_addr;
  assign o_any_free  = ~&valid_q;

  ////////////////////////////////////////////////////////////
  // Valid bits
  ////////////////////////////////////////////////////////////

  // The reserved slot is free and a released slot is busy, so the two never overlap
  assign res_mask = i_res_done ? (TotCapa'(1) << free_addr) : '0;
  assign valid_d  = (valid_q | res_mask) & ~i_rel_onehot;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

endmodule

//--- verilog/simmem_id_queues.sv
/*
 * Per-identifier linked lists over the shared slot pool.
 * Each list runs head -> filled slots -> reserved slots -> last reserved.
 * Links sit in a flip-flop array read combinationally, so a pointer
 * follows its link in the same cycle as the event.
 * Input is refused in any cycle with an output handshake.
 * Head and non-empty outputs show the state after this cycle's pop.
 */

`timescale 1ns/100ps

module simmem_id_queues
  import simmem_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Reservation handshake and the slot it takes
  input  logic                                  i_res_done,
  input  logic [NumIds-1:0]                     i_res_id_onehot,
  input  logic [BankAddrWidth-1:0]              i_res_addr,

  // Response input
  input  logic                                  i_in_valid,
  input  logic [IdWidth-1:0]                    i_in_id,
  output logic                                  o_in_ready,

  // Message memory write side
  output logic                                  o_wr_en,
  output logic [BankAddrWidth-1:0]              o_wr_addr,

  // Queue heads towards the arbiter
  output logic [NumIds-1:0][BankAddrWidth-1:0]  o_head_addr,
  output logic [NumIds-1:0]                     o_nonempty,

  // Identifier popped in this cycle, zero if none
  input  logic [NumIds-1:0]                     i_out_pop_onehot
);

  // Per-identifier pointers
  logic [BankAddrWidth-1:0] last_d [NumIds];
  logic [BankAddrWidth-1:0] last_q [NumIds];
  logic [BankAddrWidth-1:0] fill_d [NumIds];
  logic [BankAddrWidth-1:0] fill_q [NumIds];
  logic [BankAddrWidth-1:0] head_d [NumIds];
  logic [BankAddrWidth-1:0] head_q [NumIds];
  logic [BankAddrWidth-1:0] head_pop [NumIds];

  // Reserved-but-unfilled and filled-but-unpopped counts
  logic [LenWidth-1:0]      rsv_cnt_d [NumIds];
  logic [LenWidth-1:0]      rsv_cnt_q [NumIds];
  logic [LenWidth-1:0]      fil_cnt_d [NumIds];
  logic [LenWidth-1:0]      fil_cnt_q [NumIds];
  logic [LenWidth-1:0]      fil_after_pop [NumIds];

  // Next-slot links, no reset
  logic [BankAddrWidth-1:0] link_q [TotCapa];
  logic                     link_we;
  logic [BankAddrWidth-1:0] link_wa;

  logic                     in_hs;
  logic [NumIds-1:0]        res_hit;
  logic [NumIds-1:0]        in_hit;
  logic [NumIds-1:0]        q_busy;

  ////////////////////////////////////////////////////////////
  // Input acceptance
  ////////////////////////////////////////////////////////////

  assign o_in_ready = i_in_valid && (rsv_cnt_q[i_in_id] != '0) && ~|i_out_pop_onehot;
  assign in_hs      = o_in_ready;

  // The response goes to the oldest unfilled reservation
  assign o_wr_en   = in_hs;
  assign o_wr_addr = fill_q[i_in_id];

  assign res_hit = {NumIds{i_res_done}} & i_res_id_onehot;

  ////////////////////////////////////////////////////////////
  // Per-identifier pointer update
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NumIds; g++) begin : gen_queue
    assign in_hit[g] = in_hs && (i_in_id == IdWidth'(g));

    assign fil_after_pop[g] = fil_cnt_q[g] - LenWidth'(i_out_pop_onehot[g]);
    assign head_pop[g]      = i_out_pop_onehot[g] ? link_q[head_q[g]] : head_q[g];

    // Queue still holds some slot once the pop is done
    assign q_busy[g] = (rsv_cnt_q[g] != '0) || (fil_after_pop[g] != '0);

    assign o_head_addr[g] = head_pop[g];
    assign o_nonempty[g]  = fil_after_pop[g] != '0;

    always_comb begin
      rsv_cnt_d[g] = rsv_cnt_q[g] + LenWidth'(res_hit[g]) - LenWidth'(in_hit[g]);
      fil_cnt_d[g] = fil_after_pop[g] + LenWidth'(in_hit[g]);

      last_d[g] = res_hit[g] ? i_res_addr : last_q[g];

      // An empty queue restarts at the new slot
      head_d[g] = (res_hit[g] && !q_busy[g]) ? i_res_addr : head_pop[g];

      // Fill pointer jumps to the new slot when no other unfilled slot is left,
      // since the link being written this cycle cannot be read yet
      if (res_hit[g] && ((rsv_cnt_q[g] == '0) ||
                         (in_hit[g] && rsv_cnt_q[g] == LenWidth'(1)))) begin
        fill_d[g] = i_res_addr;
      end else if (in_hit[g]) begin
        fill_d[g] = link_q[fill_q[g]];
      end else begin
        fill_d[g] = fill_q[g];
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        last_q[g]    <= '0;
        fill_q[g]    <= '0;
        head_q[g]    <= '0;
        rsv_cnt_q[g] <= '0;
        fil_cnt_q[g] <= '0;
      end else begin
        last_q[g]    <= last_d[g];
        fill_q[g]    <= fill_d[g];
        head_q[g]    <= head_d[g];
        rsv_cnt_q[g] <= rsv_cnt_d[g];
        fil_cnt_q[g] <= fil_cnt_d[g];
      end
    end
  end : gen_queue

  ////////////////////////////////////////////////////////////
  // Link array
  ////////////////////////////////////////////////////////////

  // At most one reservation per cycle, so one write port is enough
  always_comb begin
    link_we = 1'b0;
    link_wa = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (res_hit[i] && q_busy[i]) begin
        link_we = 1'b1;
        link_wa = last_q[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (link_we) begin
      link_q[link_wa] <= i_res_addr;
    end
  end

endmodule

//--- verilog/simmem_release_arb.sv
/*
 * Fixed-priority release arbiter, identifier 0 highest.
 * An identifier competes when its queue is non-empty and the release
 * bit of its head slot is set. The choice is re-made every cycle and
 * registered; the memory read address comes from the unregistered
 * choice so content and offer line up in the same cycle.
 */

`timescale 1ns/100ps

module simmem_release_arb
  import simmem_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  input  logic [NumIds-1:0][BankAddrWidth-1:0]  i_head_addr,
  input  logic [NumIds-1:0]                     i_nonempty,
  input  logic [TotCapa-1:0]                    i_release_en,
  input  logic                                  i_out_ready,

  output logic [BankAddrWidth-1:0]              o_rd_addr,
  output logic [NumIds-1:0]                     o_out_pop_onehot,
  output logic [TotCapa-1:0]                    o_rel_onehot,
  output logic                                  o_out_valid,
  output logic [IdWidth-1:0]                    o_out_id
);

  logic [NumIds-1:0]        eligible;
  logic                     sel_valid;
  logic [IdWidth-1:0]       sel_id;
  logic [BankAddrWidth-1:0] sel_addr;
  logic [TotCapa-1:0]       sel_slot_onehot;

  logic                     valid_q;
  logic [IdWidth-1:0]       id_q;
  logic [TotCapa-1:0]       slot_q;
  logic                     out_hs;

  ////////////////////////////////////////////////////////////
  // Choice
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NumIds; g++) begin : gen_eligible
    assign eligible[g] = i_nonempty[g] && i_release_en[i_head_addr[g]];
  end : gen_eligible

  // Downward scan leaves the lowest eligible identifier in place
  always_comb begin
    sel_valid = 1'b0;
    sel_id    = '0;
    sel_addr  = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        sel_valid = 1'b1;
        sel_id    = IdWidth'(i);
        sel_addr  = i_head_addr[i];
      end
    end
  end

  assign sel_slot_onehot = sel_valid ? (TotCapa'(1) << sel_addr) : '0;
  assign o_rd_addr       = sel_addr;

  ////////////////////////////////////////////////////////////
  // Registered offer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      id_q    <= '0;
      slot_q  <= '0;
    end else begin
      valid_q <= sel_valid;
      id_q    <= sel_id;
      slot_q  <= sel_slot_onehot;
    end
  end

  assign o_out_valid = valid_q;
  assign o_out_id    = id_q;

  // Pop and release pulses only in the handshake cycle
  assign out_hs           = valid_q && i_out_ready;
  assign o_out_pop_onehot = out_hs ? (NumIds'(1) << id_q) : '0;
  assign o_rel_onehot     = out_hs ? slot_q : '0;

endmodule

//--- verilog/simmem_write_resp_bank.sv
/*
 * Write-response bank: up to TotCapa responses kept in per-identifier
 * order over a shared slot pool.
 * A slot must be reserved for an identifier before its response can be
 * written. Output is offered at the earliest two cycles after the input
 * handshake, and only while the slot's release bit is set.
 * Input is stalled in any cycle with an output handshake.
 */

`timescale 1ns/100ps

module simmem_write_resp_bank
  import simmem_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Reservation
  input  logic                     i_res_req_valid,
  input  logic [NumIds-1:0]        i_res_req_id_onehot,
  output logic                     o_res_req_ready,
  output logic [BankAddrWidth-1:0] o_res_addr,

  // Response input from the memory controller
  input  logic                     i_in_data_valid,
  input  logic [IdWidth-1:0]       i_in_data_id,
  input  logic [ContentWidth-1:0]  i_in_data_content,
  output logic                     o_in_data_ready,

  // Release control
  input  logic [TotCapa-1:0]       i_release_en,
  output logic [TotCapa-1:0]       o_rel_addr_onehot,

  // Response output
  input  logic                     i_out_ready,
  output logic                     o_out_valid,
  output logic [IdWidth-1:0]       o_out_id,
  output logic [ContentWidth-1:0]  o_out_content
);

  logic                                 res_done;
  logic                                 wr_en;
  logic [BankAddrWidth-1:0]             wr_addr;
  logic [BankAddrWidth-1:0]             rd_addr;
  logic [NumIds-1:0][BankAddrWidth-1:0] head_addr;
  logic [NumIds-1:0]                    nonempty;
  logic [NumIds-1:0]                    pop_onehot;
  logic [TotCapa-1:0]                   rel_onehot;

  assign res_done          = i_res_req_valid && o_res_req_ready;
  assign o_rel_addr_onehot = rel_onehot;

  simmem_slot_alloc u_slot_alloc (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_res_done   (res_done),
    .i_rel_onehot (rel_onehot),
    .o_free_addr  (o_res_addr),
    .o_any_free   (o_res_req_ready)
  );

  simmem_id_queues u_id_queues (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .i_res_done       (res_done),
    .i_res_id_onehot  (i_res_req_id_onehot),
    .i_res_addr       (o_res_addr),
    .i_in_valid       (i_in_data_valid),
    .i_in_id          (i_in_data_id),
    .o_in_ready       (o_in_data_ready),
    .o_wr_en          (wr_en),
    .o_wr_addr        (wr_addr),
    .o_head_addr      (head_addr),
    .o_nonempty       (nonempty),
    .i_out_pop_onehot (pop_onehot)
  );

  simmem_release_arb u_release_arb (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .i_head_addr      (head_addr),
    .i_nonempty       (nonempty),
    .i_release_en     (i_release_en),
    .i_out_ready      (i_out_ready),
    .o_rd_addr        (rd_addr),
    .o_out_pop_onehot (pop_onehot),
    .o_rel_onehot     (rel_onehot),
    .o_out_valid      (o_out_valid),
    .o_out_id         (o_out_id)
  );

  simmem_msg_ram u_msg_ram (
    .clk_i     (clk_i),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (i_in_data_content),
    .i_rd_addr (rd_addr),
    .o_rd_data (o_out_content)
  );

endmodule

//--- test/tb_simmem_write_resp_bank.sv
/*
 * Self-checking testbench for the write-response bank.
 * A slot-level reference model is updated at the falling edge, where
 * all inputs and outputs are stable. Offers are predicted one cycle
 * ahead from the model state after the pop of each cycle.
 */

`timescale 1ns/100ps

module tb_simmem_write_resp_bank
  import simmem_pkg::*;
();

  logic                     clk_i;
  logic                     rst_ni;
  logic                     i_res_req_valid;
  logic [NumIds-1:0]        i_res_req_id_onehot;
  logic                     o_res_req_ready;
  logic [BankAddrWidth-1:0] o_res_addr;
  logic                     i_in_data_valid;
  logic [IdWidth-1:0]       i_in_data_id;
  logic [ContentWidth-1:0]  i_in_data_content;
  logic                     o_in_data_ready;
  logic [TotCapa-1:0]       i_release_en;
  logic [TotCapa-1:0]       o_rel_addr_onehot;
  logic                     i_out_ready;
  logic                     o_out_valid;
  logic [IdWidth-1:0]       o_out_id;
  logic [ContentWidth-1:0]  o_out_content;

  // Reference model, one entry per slot
  logic [TotCapa-1:0]       m_busy;
  logic [TotCapa-1:0]       m_filled;
  logic [IdWidth-1:0]       m_id [TotCapa];
  logic [ContentWidth-1:0]  m_data [TotCapa];
  int unsigned              m_seq [TotCapa];
  int unsigned              seq_cnt;

  // Offer expected in the current cycle
  logic                     exp_valid;
  logic [IdWidth-1:0]       exp_id;
  logic [BankAddrWidth-1:0] exp_slot;

  int unsigned              val_errs;
  int unsigned              other_errs;
  logic [15:0]              lfsr_q;

  simmem_write_resp_bank uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_bits(input int unsigned n);
    logic [7:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r = {r[6:0], next_bit()};
    end
    return r;
  endfunction

  function automatic logic [IdWidth-1:0] onehot_id(input logic [NumIds-1:0] oh);
    logic [IdWidth-1:0] id;
    id = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (oh[i]) begin
        id = IdWidth'(i);
      end
    end
    return id;
  endfunction

  function automatic int lowest_free();
    for (int s = 0; s < TotCapa; s++) begin
      if (!m_busy[s]) begin
        return s;
      end
    end
    return -1;
  endfunction

  // Oldest busy slot of an identifier, optionally only unfilled ones
  function automatic int find_oldest(input logic [IdWidth-1:0] id, input logic only_unfilled);
    int best;
    best = -1;
    for (int s = 0; s < TotCapa; s++) begin
      if (m_busy[s] && m_id[s] == id && !(only_unfilled && m_filled[s])) begin
        if (best < 0 || m_seq[s] < m_seq[best]) begin
          best = s;
        end
      end
    end
    return best;
  endfunction

  // Identifier that still waits for a response, random if none does
  function automatic logic [IdWidth-1:0] pick_in_id();
    for (int s = 0; s < TotCapa; s++) begin
      if (m_busy[s] && !m_filled[s]) begin
        return m_id[s];
      end
    end
    return IdWidth'(rand_bits(2));
  endfunction

  task automatic value_fail(input string name, input logic [31:0] exp, input logic [31:0] act);
    val_errs++;
    $display("FAIL %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
  endtask

  task automatic apply(input logic res_v, input logic [IdWidth-1:0] res_id,
                       input logic in_v, input logic [IdWidth-1:0] in_id,
                       input logic [ContentWidth-1:0] data,
                       input logic [TotCapa-1:0] rel, input logic out_rdy);
    i_res_req_valid     <= res_v;
    i_res_req_id_onehot <= NumIds'(1) << res_id;
    i_in_data_valid     <= in_v;
    i_in_data_id        <= in_id;
    i_in_data_content   <= data;
    i_release_en        <= rel;
    i_out_ready         <= out_rdy;
  endtask

  // Fill pending reservations, and with full set also drain every slot
  task automatic settle(input logic full, input logic [TotCapa-1:0] rel,
                        input int unsigned limit);
    int unsigned n;
    n = 0;
    // One idle cycle so the model has seen the last stimulus
    @(posedge clk_i);
    apply(1'b0, '0, 1'b0, '0, '0, rel, 1'b1);
    while ((full ? m_busy : (m_busy & ~m_filled)) != '0 && n < limit) begin
      @(posedge clk_i);
      apply(1'b0, '0, 1'b1, pick_in_id(), ContentWidth'(rand_bits(6)), rel, 1'b1);
      n++;
    end
    if ((full ? m_busy : (m_busy & ~m_filled)) != '0) begin
      other_errs++;
      $display("Timeout: bank did not settle within %0d cycles", limit);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Model and checks
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : model_check
    int   free_s;
    int   fill_s;
    int   head_s;
    logic exp_hs;
    logic exp_in_ready;
    if (rst_ni) begin
      free_s       = lowest_free();
      exp_hs       = exp_valid && i_out_ready;
      fill_s       = find_oldest(i_in_data_id, 1'b1);
      exp_in_ready = i_in_data_valid && fill_s >= 0 && !exp_hs;

      assert (o_res_req_ready == (free_s >= 0))
        else value_fail("o_res_req_ready", 32'(free_s >= 0), 32'(o_res_req_ready));
      if (free_s >= 0) begin
        assert (o_res_addr == BankAddrWidth'(free_s))
          else value_fail("o_res_addr", 32'(free_s), 32'(o_res_addr));
      end
      assert (o_in_data_ready == exp_in_ready)
        else value_fail("o_in_data_ready", 32'(exp_in_ready), 32'(o_in_data_ready));
      assert (o_out_valid == exp_valid)
        else value_fail("o_out_valid", 32'(exp_valid), 32'(o_out_valid));
      if (exp_valid) begin
        assert (o_out_id == exp_id)
          else value_fail("o_out_id", 32'(exp_id), 32'(o_out_id));
        assert (o_out_content == m_data[exp_slot])
          else value_fail("o_out_content", 32'(m_data[exp_slot]), 32'(o_out_content));
      end
      assert (o_rel_addr_onehot == (exp_hs ? (TotCapa'(1) << exp_slot) : '0))
        else value_fail("o_rel_addr_onehot",
                        32'(exp_hs ? (TotCapa'(1) << exp_slot) : '0), 32'(o_rel_addr_onehot));

      if (exp_hs) begin
        m_busy[exp_slot]   = 1'b0;
        m_filled[exp_slot] = 1'b0;
      end

      // Next offer, lowest eligible identifier after the pop
      exp_valid = 1'b0;
      for (int i = NumIds - 1; i >= 0; i--) begin
        head_s = find_oldest(IdWidth'(i), 1'b0);
        if (head_s >= 0 && m_filled[head_s] && i_release_en[head_s]) begin
          exp_valid = 1'b1;
          exp_id    = IdWidth'(i);
          exp_slot  = BankAddrWidth'(head_s);
        end
      end

      if (exp_in_ready) begin
        m_filled[fill_s] = 1'b1;
        m_data[fill_s]   = i_in_data_content;
      end
      if (i_res_req_valid && free_s >= 0) begin
        m_busy[free_s] = 1'b1;
        m_id[free_s]   = onehot_id(i_res_req_id_onehot);
        m_seq[free_s]  = seq_cnt;
        seq_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    lfsr_q     = 16'd44;
    m_busy     = '0;
    m_filled   = '0;
    seq_cnt    = 0;
    exp_valid  = 1'b0;
    exp_id     = '0;
    exp_slot   = '0;
    val_errs   = 0;
    other_errs = 0;
    rst_ni              = 1'b0;
    i_res_req_valid     = 1'b0;
    i_res_req_id_onehot = '0;
    i_in_data_valid     = 1'b0;
    i_in_data_id        = '0;
    i_in_data_content   = '0;
    i_release_en        = '0;
    i_out_ready         = 1'b0;

    @(negedge clk_i);
    assert (!o_out_valid && !o_in_data_ready && o_res_req_ready && o_res_addr == '0 &&
            o_rel_addr_onehot == '0)
      else begin
        other_errs++;
        $display("Outputs are not in their reset state");
      end
    @(posedge clk_i);
    rst_ni <= 1'b1;

    // Fill the pool, two slots per identifier, then one refused request
    for (int k = 0; k <= TotCapa; k++) begin
      @(posedge clk_i);
      apply(1'b1, IdWidth'(k), 1'b0, '0, '0, '0, 1'b1);
    end
    settle(1'b0, '0, 4 * TotCapa);

    // Nothing is unfilled now, and held slots must not leave
    @(posedge clk_i);
    apply(1'b0, '0, 1'b1, IdWidth'(rand_bits(2)), '0, '0, 1'b1);

    // Back-pressure with all slots released
    repeat (4) begin
      @(posedge clk_i);
      apply(1'b0, '0, 1'b0, '0, '0, '1, 1'b0);
    end
    settle(1'b1, '1, 8 * TotCapa);

    for (int c = 0; c < 400; c++) begin
      @(posedge clk_i);
      apply(next_bit(), IdWidth'(rand_bits(2)), next_bit(),
            next_bit() ? pick_in_id() : IdWidth'(rand_bits(2)),
            ContentWidth'(rand_bits(6)), rand_bits(8) | rand_bits(8), next_bit());
    end
    settle(1'b1, '1, 8 * TotCapa);

    @(negedge clk_i);
    assert (m_busy == '0)
      else begin
        other_errs++;
        $display("Responses are still held in the model after the drain");
      end

    $display("Closing: %0d value errors, %0d other errors", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- simmem_resp_bank.f
verilog/simmem_pkg.sv
verilog/simmem_msg_ram.sv
verilog/simmem_slot_alloc.sv
verilog/simmem_id_queues.sv
verilog/simmem_release_arb.sv
verilog/simmem_write_resp_bank.sv
test/tb_simmem_write_resp_bank.sv

//--- Makefile
# Verilator build and run for the write-response bank testbench

VERILATOR ?= verilator
TOP       ?= tb_simmem_write_resp_bank
FILELIST  ?= simmem_resp_bank.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a listed source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
